//--- compile.f
+incdir+logic
logic/id_tracker_pkg.sv
logic/toggle_memory.sv
logic/toggle_memory_set.sv
logic/clear_sequencer.sv
logic/id_tracker_top.sv
verif/id_tracker_tb.sv

//--- verif/id_tracker_tb.sv
// Stops at the first mismatch; toggles are only driven while busy is low, queries checked at negedge
`timescale 1ns/100ps

`include "id_tracker_consts.svh"

module id_tracker_tb
    import id_tracker_pkg::*;
;

    localparam int DEPTH         = `ID_TRACK_DEPTH;
    localparam int CLK_PERIOD    = 4;
    localparam int STRESS_CYCLES = 300;
    localparam int FILL_CYCLES   = 40;
    // Reset, directed tests, stress, two clears with read-back, random fill, second reset
    localparam int TOTAL_CYCLES  = 10 + 30 + STRESS_CYCLES + 2 * (2 * DEPTH + 8) + FILL_CYCLES + 10;

    logic clk;
    logic arst_n;
    logic issue, retire_a, retire_b;
    id_t  issue_id, retire_a_id, retire_b_id;
    id_t  query_a_id, query_b_id;
    logic query_a_in_use, query_b_in_use;
    logic clear_req, clear_ack, busy;

    // Reference in-use bits
    logic [DEPTH-1:0] model_bits;
    logic [31:0]      rng_state;
    string            test_name;

    id_tracker_top DUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .issue          (issue),
        .issue_id       (issue_id),
        .retire_a       (retire_a),
        .retire_a_id    (retire_a_id),
        .retire_b       (retire_b),
        .retire_b_id    (retire_b_id),
        .query_a_id     (query_a_id),
        .query_a_in_use (query_a_in_use),
        .query_b_id     (query_b_id),
        .query_b_in_use (query_b_in_use),
        .clear_req      (clear_req),
        .clear_ack      (clear_ack),
        .busy           (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic stop_with_error();
        $display("Verification failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_bit(input string what, input logic exp, input logic act);
        assert (act === exp) else begin
            $display("ERR %s %s: expected %0b actual %0b", test_name, what, exp, act);
            stop_with_error();
        end
    endtask

    // One cycle of toggle pulses
    task automatic toggle_cycle(input logic i_en, input id_t i_id, input logic a_en,
                                input id_t a_id, input logic b_en, input id_t b_id);
        @(posedge clk);
        issue       <= i_en;
        issue_id    <= i_id;
        retire_a    <= a_en;
        retire_a_id <= a_id;
        retire_b    <= b_en;
        retire_b_id <= b_id;
    endtask

    // Idle the toggles, query one ID on both ports, compare with a fixed value
    task automatic expect_state(input id_t id, input logic exp);
        @(posedge clk);
        issue      <= 1'b0;
        retire_a   <= 1'b0;
        retire_b   <= 1'b0;
        query_a_id <= id;
        query_b_id <= id;
        @(negedge clk);
        check_bit($sformatf("query_a id %0d", id), exp, query_a_in_use);
        check_bit($sformatf("query_b id %0d", id), exp, query_b_in_use);
    endtask

    task automatic random_toggles(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            rng_state = xorshift32(rng_state);
            @(posedge clk);
            issue       <= rng_state[0];
            retire_a    <= rng_state[1];
            retire_b    <= rng_state[2];
            issue_id    <= id_t'(rng_state >> 4);
            retire_a_id <= id_t'(rng_state >> 8);
            retire_b_id <= id_t'(rng_state >> 12);
            query_a_id  <= id_t'(rng_state >> 16);
            query_b_id  <= id_t'(rng_state >> 20);
        end
        toggle_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic hold_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_bit("clear_ack after reset", 1'b0, clear_ack);
        check_bit("busy after reset", 1'b0, busy);
    endtask

    // Full four-phase clear with cycle-exact timing
    task automatic run_clear();
        @(posedge clk);
        clear_req <= 1'b1;
        // Request visible but not yet sampled
        @(negedge clk);
        check_bit("busy before sample", 1'b0, busy);
        for (int cyc = 1; cyc <= DEPTH + 1; cyc++) begin
            @(negedge clk);
            check_bit($sformatf("busy cycle %0d", cyc), 1'b1, busy);
            check_bit($sformatf("clear_ack cycle %0d", cyc), cyc == DEPTH + 1, clear_ack);
        end
        @(posedge clk);
        clear_req <= 1'b0;
        @(negedge clk);
        check_bit("clear_ack held", 1'b1, clear_ack);
        @(negedge clk);
        check_bit("clear_ack dropped", 1'b0, clear_ack);
        check_bit("busy dropped", 1'b0, busy);
    endtask

    ////////////////////////////////////////
    // Reference model and checker
    ////////////////////////////////////////

    // Each pulse flips once, so same-cycle pulses XOR; a clear request empties the set
    always @(posedge clk) begin : model_update
        logic [DEPTH-1:0] next_bits;
        next_bits = model_bits;
        if (issue)    next_bits[issue_id]    = ~next_bits[issue_id];
        if (retire_a) next_bits[retire_a_id] = ~next_bits[retire_a_id];
        if (retire_b) next_bits[retire_b_id] = ~next_bits[retire_b_id];
        model_bits <= clear_req ? '0 : next_bits;
    end

    // Read port 0 belongs to the sweep while a clear is requested
    always @(negedge clk) begin
        if (arst_n && !clear_req) begin
            check_bit($sformatf("model query_a id %0d", query_a_id),
                      model_bits[query_a_id], query_a_in_use);
            check_bit($sformatf("model query_b id %0d", query_b_id),
                      model_bits[query_b_id], query_b_in_use);
        end
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD * 2);
        $display("Timeout: the tests did not finish in the expected time");
        stop_with_error();
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        issue       = 1'b0;
        issue_id    = '0;
        retire_a    = 1'b0;
        retire_a_id = '0;
        retire_b    = 1'b0;
        retire_b_id = '0;
        query_a_id  = '0;
        query_b_id  = '0;
        clear_req   = 1'b0;
        model_bits  = '0;
        rng_state   = 32'd10457;

        test_name = "reset_state";
        hold_reset();

        test_name = "single_toggle";
        toggle_cycle(1'b1, 4'd3, 1'b0, '0, 1'b0, '0);
        expect_state(4'd3, 1'b1);
        toggle_cycle(1'b0, '0, 1'b1, 4'd3, 1'b0, '0);
        expect_state(4'd3, 1'b0);
        toggle_cycle(1'b1, 4'd9, 1'b0, '0, 1'b0, '0);
        toggle_cycle(1'b0, '0, 1'b0, '0, 1'b1, 4'd9);
        expect_state(4'd9, 1'b0);

        test_name = "same_cycle";
        toggle_cycle(1'b1, 4'd5, 1'b0, '0, 1'b0, '0);
        expect_state(4'd5, 1'b1);
        // Issue and retire_a cancel out
        toggle_cycle(1'b1, 4'd5, 1'b1, 4'd5, 1'b0, '0);
        expect_state(4'd5, 1'b1);
        // Three flips leave it free
        toggle_cycle(1'b1, 4'd5, 1'b1, 4'd5, 1'b1, 4'd5);
        expect_state(4'd5, 1'b0);

        test_name = "random_stress";
        random_toggles(STRESS_CYCLES);

        test_name = "clear_timing";
        run_clear();
        test_name = "clear_contents";
        for (int id = 0; id < DEPTH; id++) begin
            expect_state(id_t'(id), 1'b0);
        end

        // Memories survive the reset, so the clear has real work to do
        test_name = "reset_then_clear";
        random_toggles(FILL_CYCLES);
        hold_reset();
        run_clear();
        for (int id = 0; id < DEPTH; id++) begin
            expect_state(id_t'(id), 1'b0);
        end

        $display("Verification passed");
        $finish;
    end

endmodule

//--- logic/id_tracker_top.sv
// No back-pressure: toggles are never refused and must be held off by the user while busy is high
`timescale 1ns/100ps

`include "id_tracker_consts.svh"

module id_tracker_top
    import id_tracker_pkg::*;
(
    input  logic clk,
    input  logic arst_n,

    // Toggle ports, one-cycle pulses
    input  logic issue,
    input  id_t  issue_id,
    input  logic retire_a,
    input  id_t  retire_a_id,
    input  logic retire_b,
    input  id_t  retire_b_id,

    // Query ports
    input  id_t  query_a_id,
    output logic query_a_in_use,
    input  id_t  query_b_id,
    output logic query_b_in_use,

    // Clear handshake
    input  logic clear_req,
    output logic clear_ack,
    output logic busy
);

    ////////////////////////////////////////
    // Port packing
    ////////////////////////////////////////

    logic toggle_vec    [`ID_TRACK_WRITE_PORTS];
    id_t  toggle_id_vec [`ID_TRACK_WRITE_PORTS];
    id_t  read_id_vec   [`ID_TRACK_READ_PORTS];
    logic in_use_vec    [`ID_TRACK_READ_PORTS];

    logic init_clear;
    logic clear_last;

    // Write ports in write_port_e order
    assign toggle_vec[issue_port]       = issue;
    assign toggle_id_vec[issue_port]    = issue_id;
    assign toggle_vec[retire_a_port]    = retire_a;
    assign toggle_id_vec[retire_a_port] = retire_a_id;
    assign toggle_vec[retire_b_port]    = retire_b;
    assign toggle_id_vec[retire_b_port] = retire_b_id;

    // Query a sits on read port 0 and shows the swept ID during a clear
    assign read_id_vec[0] = query_a_id;
    assign read_id_vec[1] = query_b_id;
    assign query_a_in_use = in_use_vec[0];
    assign query_b_in_use = in_use_vec[1];

    ////////////////////////////////////////
    // Instances
    ////////////////////////////////////////

    clear_sequencer u_clear_seq (
        .clk        (clk),
        .arst_n     (arst_n),
        .clear_req  (clear_req),
        .clear_ack  (clear_ack),
        .busy       (busy),
        .clear_last (clear_last),
        .init_clear (init_clear)
    );

    toggle_memory_set #(
        .DEPTH            (`ID_TRACK_DEPTH),
        .NUM_WRITE_PORTS  (`ID_TRACK_WRITE_PORTS),
        .NUM_READ_PORTS   (`ID_TRACK_READ_PORTS),
        .CLEAR_WRITE_PORT (int'(issue_port)),
        .CLEAR_READ_PORT  (0)
    ) u_mem_set (
        .clk        (clk),
        .arst_n     (arst_n),
        .init_clear (init_clear),
        .toggle     (toggle_vec),
        .toggle_id  (toggle_id_vec),
        .read_id    (read_id_vec),
        .in_use     (in_use_vec),
        .clear_last (clear_last)
    );

endmodule

//--- logic/clear_sequencer.sv
// Expects a four-phase clear_req; clear_req must stay low until clear_ack has dropped
`timescale 1ns/100ps

module clear_sequencer (
    input  logic clk,
    input  logic arst_n,

    // Handshake with the user
    input  logic clear_req,
    output logic clear_ack,
    output logic busy,

    // Sweep control towards the memory set
    input  logic clear_last,
    output logic init_clear
);

    ////////////////////////////////////////
    // State machine
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_sweep = 2'd1,
        st_ack   = 2'd2
    } clear_state_e;

    clear_state_e state;
    clear_state_e state_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            // Start the sweep on a request
            st_idle: begin
                if (clear_req) begin
                    state_next = st_sweep;
                end
            end
            // One ID per cycle until the memory set flags the last one
            st_sweep: begin
                if (clear_last) begin
                    state_next = st_ack;
                end
            end
            // Hold the ack until the request drops
            st_ack: begin
                if (!clear_req) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////

    // Decoded from the state register only
    assign init_clear = (state == st_sweep);
    assign clear_ack  = (state == st_ack);

    // Toggles are not allowed while busy
    assign busy = init_clear || clear_ack;

endmodule

//--- logic/toggle_memory_set.sv
// Users must hold toggles on the clearing write port while init_clear is high; ID width from id_t
`timescale 1ns/100ps

module toggle_memory_set
    import id_tracker_pkg::*;
    #(
        parameter int DEPTH            = 16,
        parameter int NUM_WRITE_PORTS  = 3,
        parameter int NUM_READ_PORTS   = 2,
        parameter int CLEAR_WRITE_PORT = 0,
        parameter int CLEAR_READ_PORT  = 0
    )
    (
        input  logic clk,
        input  logic arst_n,
        input  logic init_clear,

        // Toggle ports
        input  logic toggle    [NUM_WRITE_PORTS],
        input  id_t  toggle_id [NUM_WRITE_PORTS],

        // Query ports
        input  id_t  read_id   [NUM_READ_PORTS],
        output logic in_use    [NUM_READ_PORTS],

        // High on the final swept index
        output logic clear_last
    );

    ////////////////////////////////////////
    // Clearing index
    ////////////////////////////////////////

    id_t clear_index;

    // Last index of the sweep
    assign clear_last = init_clear && (clear_index == id_t'(DEPTH - 1));

    // Walks every ID once per sweep, back to zero at the end
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clear_index <= '0;
        end else if (clear_last) begin
            clear_index <= '0;
        end else if (init_clear) begin
            clear_index <= clear_index + 1'b1;
        end
    end

    ////////////////////////////////////////
    // Port steering
    ////////////////////////////////////////

    logic mem_toggle    [NUM_WRITE_PORTS];
    id_t  mem_toggle_id [NUM_WRITE_PORTS];
    id_t  mem_read_id   [NUM_READ_PORTS];

    always_comb begin
        for (int w = 0; w < NUM_WRITE_PORTS; w++) begin
            mem_toggle[w]    = toggle[w];
            mem_toggle_id[w] = toggle_id[w];
        end
        for (int r = 0; r < NUM_READ_PORTS; r++) begin
            mem_read_id[r] = read_id[r];
        end

        // Sweep takes over one write and one read port
        // Flip only set entries so each ID ends up free
        if (init_clear) begin
            mem_toggle_id[CLEAR_WRITE_PORT] = clear_index;
            mem_read_id[CLEAR_READ_PORT]    = clear_index;
            mem_toggle[CLEAR_WRITE_PORT]    = in_use[CLEAR_READ_PORT];
        end
    end

    ////////////////////////////////////////
    // Memory grid
    ////////////////////////////////////////

    // One copy of each write port's bits per read port
    logic read_data [NUM_WRITE_PORTS][NUM_READ_PORTS];

    for (genvar r = 0; r < NUM_READ_PORTS; r++) begin : g_read
        for (genvar w = 0; w < NUM_WRITE_PORTS; w++) begin : g_write
            toggle_memory #(
                .DEPTH (DEPTH)
            ) u_mem (
                .clk       (clk),
                .toggle    (mem_toggle[w]),
                .toggle_id (mem_toggle_id[w]),
                .read_id   (mem_read_id[r]),
                .read_data (read_data[w][r])
            );
        end
    end

    // In use is the parity of all write ports for that ID
    always_comb begin
        for (int r = 0; r < NUM_READ_PORTS; r++) begin
            in_use[r] = 1'b0;
            for (int w = 0; w < NUM_WRITE_PORTS; w++) begin
                in_use[r] = in_use[r] ^ read_data[w][r];
            end
        end
    end

endmodule

//--- logic/toggle_memory.sv
// No reset: contents start at zero only through the initial value (simulation and FPGA)
`timescale 1ns/100ps

module toggle_memory
    import id_tracker_pkg::*;
    #(
        parameter int DEPTH = 16
    )
    (
        input  logic clk,

        // Flip request for one entry
        input  logic toggle,
        input  id_t  toggle_id,

        // Combinational read port
        input  id_t  read_id,
        output logic read_data
    );

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    // One bit per ID
    logic mem [DEPTH] = '{default: 1'b0};

    // Internal read port for the read-modify-write
    logic toggle_bit;

    assign toggle_bit = mem[toggle_id];

    // Write back the inverted bit on a toggle
    always_ff @(posedge clk) begin
        if (toggle) begin
            mem[toggle_id] <= ~toggle_bit;
        end
    end

    ////////////////////////////////////////
    // External read
    ////////////////////////////////////////

    // Asynchronous read, follows read_id in the same cycle
    // Maps to distributed RAM on FPGA
    assign read_data = mem[read_id];

endmodule

//--- logic/id_tracker_pkg.sv
// Types for the ID tracker; write port order must match ID_TRACK_WRITE_PORTS in the consts header
`include "id_tracker_consts.svh"

package id_tracker_pkg;

    ////////////////////////////////////////
    // Shared types
    ////////////////////////////////////////

    // One tracked ID
    typedef logic [$clog2(`ID_TRACK_DEPTH)-1:0] id_t;

    // Write port indices into the toggle arrays
    // Issue port doubles as the clearing port
    typedef enum logic [1:0] {
        issue_port    = 2'd0,
        retire_a_port = 2'd1,
        retire_b_port = 2'd2
    } write_port_e;

endpackage

//--- logic/id_tracker_consts.svh
// Sizes for the ID tracker. DEPTH must be at least 2 and the read/write port counts fixed at 2/3
`ifndef ID_TRACKER_CONSTS_SVH
`define ID_TRACKER_CONSTS_SVH

////////////////////////////////////////
// Tracker geometry
////////////////////////////////////////

// Number of tracked IDs
`define ID_TRACK_DEPTH 16

// Toggle ports: issue plus two retire ports
`define ID_TRACK_WRITE_PORTS 3

// Query ports
`define ID_TRACK_READ_PORTS 2

`endif
